// ==== filelist.f ====
hdl/spi_pkg.sv
hdl/spi_xfer_if.sv
hdl/spi_cmd_queue.sv
hdl/spi_shift_engine.sv
hdl/spi_rx_queue.sv
hdl/spi_master_top.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the spi master testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_master \
    -f filelist.f -Mdir obj_dir -o tb_spi_master > build.log 2>&1 \
    && ./obj_dir/tb_spi_master > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished clean"

// ==== verification/tb_spi_master.sv ====
module tb_spi_master;

    import spi_pkg::*;

    localparam int     n_rand      = 8;                       // transfers per random test
    localparam int     longest_cyc = 2 * data_w * 16 + 8;     // div code 3 plus issue and done
    localparam int     n_xfers     = 3 * n_rand + cmd_depth + rx_depth;
    localparam longint timeout     = longint'(n_xfers + 4) * longest_cyc * 100 * 3;

    logic              sck;
    logic              clr;
    logic              cmd_push;
    logic [data_w-1:0] cmd_data;
    logic              cmd_msb;
    logic [div_w-1:0]  cmd_div;
    logic              cmd_full;
    logic              rx_pop;
    logic [data_w-1:0] rx_data;
    logic              rx_empty;
    logic              miso;
    logic              ss;
    logic              sclk;
    logic              mosi;

    logic [7:0]  slv_resp;
    logic [7:0]  slv_line;
    logic        slv_msb;
    int          slv_bits;
    int          slv_hmin;
    int          slv_hmax;
    int          slv_done;

    // one entry per accepted command in push order
    logic [7:0]  data_log [64];
    logic        msb_log  [64];
    logic [1:0]  div_log  [64];
    logic [7:0]  resp_log [64];

    int          n_push    = 0;
    int          n_pop     = 0;
    int          errors    = 0;
    logic        pop_en    = 1'b0;     // host pops while set
    logic [31:0] lcg_state = 32'hbbc3_89a6;

    assign slv_resp = resp_log[slv_done[5:0]];   // response for the transfer in flight
    assign slv_msb  = msb_log[slv_done[5:0]];

    spi_master_top i_dut (.*);

    spi_slave_model i_slave (
        .ss        (ss),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .resp      (slv_resp),
        .resp_msb  (slv_msb),
        .line_bits (slv_line),
        .bits      (slv_bits),
        .half_min  (slv_hmin),
        .half_max  (slv_hmax),
        .n_done    (slv_done)
    );

    initial begin
        sck = 1'b0;
        forever #50 sck = ~sck;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers and reference model
    function automatic logic [7:0] next_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    function automatic logic [1:0] pick_div();
        logic [7:0] r;
        r = next_byte();
        return r[7:6];
    endfunction

    // rx byte is the slave response and the wire order follows the command's bit order
    function automatic void expect_xfer(input logic [7:0] data, input logic msb,
                                        input logic [7:0] resp, output logic [7:0] exp_rx,
                                        output logic [7:0] exp_line);
        int i;
        exp_rx = resp;
        for (i = 0; i < 8; i++)
            exp_line[7-i] = msb ? data[7-i] : data[i];   // i-th bit on mosi
    endfunction

    task automatic push_cmd(input logic [7:0] data, input logic msb, input logic [1:0] div);
        @(posedge sck);
        #10;
        while (cmd_full) begin
            @(posedge sck);
            #10;
        end
        data_log[n_push[5:0]] = data;
        msb_log[n_push[5:0]]  = msb;
        div_log[n_push[5:0]]  = div;
        resp_log[n_push[5:0]] = next_byte();
        n_push++;
        cmd_push = 1'b1;
        cmd_data = data;
        cmd_msb  = msb;
        cmd_div  = div;
        @(posedge sck);
        #10;
        cmd_push = 1'b0;
    endtask

    task automatic drain();
        wait (n_pop == n_push && slv_done == n_push);
        repeat (2) @(posedge sck);
    endtask

    //////////////////////////////////////////////////////////////////////
    // host pop side that compares every byte it takes
    initial begin
        logic [7:0] exp_rx;
        logic [7:0] exp_line;
        rx_pop = 1'b0;
        forever begin
            @(posedge sck);
            #10;
            rx_pop = 1'b0;
            if (pop_en && !rx_empty) begin
                assert (n_pop < n_push) else begin
                    $display("FAILED at %0t: rx queue returned a byte that no command asked for",
                             $time);
                    errors++;
                end
                if (n_pop < n_push) begin
                    expect_xfer(data_log[n_pop[5:0]], msb_log[n_pop[5:0]],
                                resp_log[n_pop[5:0]], exp_rx, exp_line);
                    assert (rx_data == exp_rx) else begin
                        $display("FAILED at %0t: rx_data = %h, expected %h", $time, rx_data,
                                 exp_rx);
                        errors++;
                    end
                end
                n_pop++;
                rx_pop = 1'b1;
            end
        end
    end

    // wire side is checked as ss closes each transfer
    initial begin
        logic [7:0] exp_rx;
        logic [7:0] exp_line;
        int         idx;
        int         hp;
        forever begin
            @(slv_done);
            idx = slv_done - 1;
            assert (idx < n_push) else begin
                $display("FAILED at %0t: transfer %0d ran with no command behind it", $time,
                         idx);
                errors++;
            end
            if (idx < n_push) begin
                expect_xfer(data_log[idx[5:0]], msb_log[idx[5:0]], resp_log[idx[5:0]],
                            exp_rx, exp_line);
                hp = (2 << div_log[idx[5:0]]) * 100;    // sck/4 .. sck/32
                assert (slv_line == exp_line) else begin
                    $display("FAILED at %0t: mosi = %h, expected %h", $time, slv_line, exp_line);
                    errors++;
                end
                assert (slv_bits == data_w) else begin
                    $display("FAILED at %0t: ss rose after %0d sclk rises, expected %0d", $time,
                             slv_bits, data_w);
                    errors++;
                end
                assert (slv_hmin == hp && slv_hmax == hp) else begin
                    $display("FAILED at %0t: sclk half period = %0d..%0d, expected %0d", $time,
                             slv_hmin, slv_hmax, hp);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(timeout);
        $display("timeout: %0d of %0d transfers done, %0d popped", slv_done, n_push, n_pop);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        int err_mark;
        int base;
        int i;
        clr      = 1'b1;
        cmd_push = 1'b0;
        cmd_data = '0;
        cmd_msb  = 1'b0;
        cmd_div  = '0;
        repeat (4) @(posedge sck);
        #10;
        clr = 1'b0;

        err_mark = errors;
        @(posedge sck);
        #10;
        assert (ss && sclk && mosi) else begin
            $display("FAILED at %0t: ss sclk mosi = %b%b%b, expected 111", $time, ss, sclk, mosi);
            errors++;
        end
        assert (rx_empty && !cmd_full) else begin
            $display("FAILED at %0t: rx_empty cmd_full = %b%b, expected 10", $time, rx_empty,
                     cmd_full);
            errors++;
        end
        $display("test 1 reset state: %0d errors", errors - err_mark);

        err_mark = errors;
        pop_en   = 1'b1;
        for (i = 0; i < n_rand; i++)
            push_cmd(next_byte(), 1'b1, pick_div());
        drain();
        $display("test 2 msb first: %0d errors", errors - err_mark);

        err_mark = errors;
        for (i = 0; i < n_rand; i++)
            push_cmd(next_byte(), 1'b0, pick_div());
        drain();
        $display("test 3 lsb first: %0d errors", errors - err_mark);

        err_mark = errors;
        for (i = 0; i < 8; i++)
            push_cmd(next_byte(), i[0], i[2:1]);   // two per divider code
        drain();
        $display("test 4 clock divider: %0d errors", errors - err_mark);

        // without pops the credits run out and the command queue fills
        err_mark = errors;
        pop_en   = 1'b0;
        base     = n_push;
        for (i = 0; i < cmd_depth + rx_depth; i++)
            push_cmd(next_byte(), i[0], 2'd0);
        wait (slv_done == base + rx_depth);
        repeat (2 * longest_cyc) @(posedge sck);
        #10;
        assert (slv_done - base == rx_depth) else begin
            $display("FAILED at %0t: transfers without pops = %0d, expected %0d", $time,
                     slv_done - base, rx_depth);
            errors++;
        end
        assert (ss && cmd_full) else begin
            $display("FAILED at %0t: ss cmd_full = %b%b, expected 11", $time, ss, cmd_full);
            errors++;
        end
        cmd_push = 1'b1;                   // must be dropped while full
        cmd_data = 8'h5a;
        @(posedge sck);
        #10;
        cmd_push = 1'b0;
        pop_en   = 1'b1;
        drain();
        repeat (longest_cyc) @(posedge sck);
        #10;
        assert (rx_empty && slv_done == n_push && n_pop == n_push) else begin
            $display("FAILED at %0t: extra traffic after drain, %0d transfers for %0d commands",
                     $time, slv_done, n_push);
            errors++;
        end
        $display("test 5 back-pressure: %0d errors", errors - err_mark);

        $display("summary: %0d commands, %0d transfers, %0d popped, %0d errors", n_push,
                 slv_done, n_pop, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== verification/spi_slave_model.sv ====
module spi_slave_model (
    input  logic       ss,
    input  logic       sclk,
    input  logic       mosi,
    output logic       miso,
    input  logic [7:0] resp,        // byte returned in the coming transfer
    input  logic       resp_msb,    // bit order of that transfer
    output logic [7:0] line_bits,   // mosi bits in arrival order with the first at bit 7
    output int         bits,        // rising sclk edges while selected
    output int         half_min,    // shortest sclk half period seen
    output int         half_max,
    output int         n_done       // finished transfers
);

    logic [7:0] tx;
    logic       msb;
    logic       active = 1'b0;
    time        last_edge;
    int         gap;

    initial begin
        miso      = 1'b1;
        line_bits = '1;
        bits      = 0;
        half_min  = 0;
        half_max  = 0;
        n_done    = 0;
    end

    // select opens a transfer and the first response bit goes out at once
    always @(negedge ss) begin
        active    = 1'b1;
        tx        = resp;
        msb       = resp_msb;
        miso      = resp_msb ? resp[7] : resp[0];
        line_bits = '1;
        bits      = 0;
        half_min  = 32'h7fff_ffff;
        half_max  = 0;
        last_edge = $time;             // ss fall starts the first half period
    end

    //////////////////////////////////////////////////////////////////////
    // mode 3 samples on rising sclk and sends the next bit after each later fall
    always @(sclk) begin
        if (active && !ss) begin
            gap = int'($time - last_edge);
            if (gap < half_min)
                half_min = gap;
            if (gap > half_max)
                half_max = gap;
            last_edge = $time;
            if (sclk) begin
                line_bits = {line_bits[6:0], mosi};
                bits++;
            end else if (bits > 0) begin
                tx   = msb ? {tx[6:0], 1'b1} : {1'b1, tx[7:1]};
                miso = msb ? tx[7] : tx[0];
            end
        end
    end

    always @(posedge ss) begin
        if (active) begin              // ignores the rise out of reset
            active = 1'b0;
            miso   = 1'b1;
            n_done++;
        end
    end

endmodule

// ==== hdl/spi_master_top.sv ====
module spi_master_top (
    input  logic                       sck,
    input  logic                       clr,
    // host command side
    input  logic                       cmd_push,
    input  logic [spi_pkg::data_w-1:0] cmd_data,
    input  logic                       cmd_msb,
    input  logic [spi_pkg::div_w-1:0]  cmd_div,
    output logic                       cmd_full,
    // host receive side
    input  logic                       rx_pop,
    output logic [spi_pkg::data_w-1:0] rx_data,
    output logic                       rx_empty,
    // spi pins
    input  logic                       miso,
    output logic                       ss,
    output logic                       sclk,
    output logic                       mosi
);

    logic rx_credit;       // pop credit back to the issuer

    spi_xfer_if xfer ();   // issue and completion between queue and engine

    //////////////////////////////////////////////////////////////////////
    // command queue issues under engine and receive credits
    spi_cmd_queue i_cmd_queue (
        .sck       (sck),
        .clr       (clr),
        .cmd_push  (cmd_push),
        .cmd_data  (cmd_data),
        .cmd_msb   (cmd_msb),
        .cmd_div   (cmd_div),
        .cmd_full  (cmd_full),
        .rx_credit (rx_credit),
        .xfer      (xfer.issuer)
    );

    // one mode-3 byte per start
    spi_shift_engine i_shift_engine (
        .sck  (sck),
        .clr  (clr),
        .xfer (xfer.engine),
        .miso (miso),
        .ss   (ss),
        .sclk (sclk),
        .mosi (mosi)
    );

    // received bytes wait here for the host
    spi_rx_queue i_rx_queue (
        .sck       (sck),
        .clr       (clr),
        .done      (xfer.done),
        .rx_byte   (xfer.rx_byte),
        .rx_pop    (rx_pop),
        .rx_data   (rx_data),
        .rx_empty  (rx_empty),
        .rx_credit (rx_credit)
    );

endmodule

// ==== hdl/spi_rx_queue.sv ====
module spi_rx_queue (
    input  logic                       sck,
    input  logic                       clr,
    input  logic                       done,
    input  logic [spi_pkg::data_w-1:0] rx_byte,
    input  logic                       rx_pop,
    output logic [spi_pkg::data_w-1:0] rx_data,
    output logic                       rx_empty,
    output logic                       rx_credit
);

    import spi_pkg::*;

    logic [data_w-1:0]      mem [rx_depth];
    logic [rx_ptr_w-1:0]    wr_ptr;
    logic [rx_ptr_w-1:0]    rd_ptr;
    logic [rx_credit_w-1:0] fill;         // bytes waiting for the host
    logic                   pop_ok;

    assign rx_empty = (fill == '0);
    assign pop_ok   = rx_pop && !rx_empty;
    assign rx_data  = mem[rd_ptr];          // head always visible

    //////////////////////////////////////////////////////////////////////
    // write side
    // a credit was spent before the transfer so a slot is always free
    always_ff @(posedge sck) begin
        if (done)
            mem[wr_ptr] <= rx_byte;
    end

    //////////////////////////////////////////////////////////////////////
    // pointers, fill and credit return
    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            rx_credit <= 1'b0;
        end else begin
            rx_credit <= pop_ok;            // one slot freed per pop
            if (done)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({done, pop_ok})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;      // write and pop together
            endcase
        end
    end

endmodule

// ==== hdl/spi_shift_engine.sv ====
module spi_shift_engine (
    input  logic       sck,
    input  logic       clr,
    spi_xfer_if.engine xfer,
    input  logic       miso,
    output logic       ss,
    output logic       sclk,
    output logic       mosi
);

    import spi_pkg::*;

    logic [st_w-1:0]   state;

    // latched at start
    logic [half_w-1:0] hp;          // half period for this transfer
    logic              msb_first;

    // shift registers
    logic [data_w-1:0] tx_sr;       // current bit sits at the output end
    logic [data_w-1:0] rx_sr;

    // timing
    logic [half_w-1:0] half_cnt;
    logic [bit_w-1:0]  bit_cnt;     // rising edges seen so far

    logic              load;
    logic              half_end;
    logic              fall;
    logic              rise;
    logic              shift_out;
    logic              last_bit;

    //////////////////////////////////////////////////////////////////////
    // edge strobes
    // sclk is a register so the edge happens at the sck edge that toggles it

    assign load     = (state == st_idle) && xfer.start;
    assign half_end = (state == st_shift) && (half_cnt == hp - 1'b1);
    assign fall     = half_end && sclk;                  // high going low
    assign rise     = half_end && !sclk;                 // low going high

    // first bit already on mosi since start so the first fall keeps it
    assign shift_out = fall && (bit_cnt != '0);

    assign last_bit = rise && (bit_cnt == bit_w'(data_w - 1));

    assign xfer.rx_byte = rx_sr;                         // stable while done is high

    //////////////////////////////////////////////////////////////////////
    // control FSM and pins
    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            state     <= st_idle;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b1;                   // mode 3 idles high
            ss        <= 1'b1;
            mosi      <= idle_word[0];
            xfer.done <= 1'b0;
        end else begin
            xfer.done <= 1'b0;
            case (state)
                st_idle: begin
                    if (xfer.start) begin
                        state    <= st_shift;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                        ss       <= 1'b0;        // select for the whole byte
                        mosi     <= xfer.msb_first ? xfer.tx_byte[data_w-1]
                                                   : xfer.tx_byte[0];
                    end
                end
                st_shift: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk     <= ~sclk;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                    // next bit goes out after a falling edge
                    if (shift_out)
                        mosi <= msb_first ? tx_sr[data_w-2] : tx_sr[1];
                    if (rise)
                        bit_cnt <= bit_cnt + 1'b1;   // wraps after the last sample
                    if (last_bit)
                        state <= st_finish;
                end
                st_finish: begin
                    // one sck after the 8th rise so the slave sees a clean edge
                    state     <= st_idle;
                    ss        <= 1'b1;
                    mosi      <= idle_word[0];
                    xfer.done <= 1'b1;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // transfer latches and shift registers
    always_ff @(posedge sck) begin
        if (load) begin
            tx_sr     <= xfer.tx_byte;
            rx_sr     <= idle_word;
            msb_first <= xfer.msb_first;
            hp        <= half_period[xfer.div];
        end else begin
            if (shift_out) begin
                // drop the bit just sent and fill with 1
                if (msb_first)
                    tx_sr <= {tx_sr[data_w-2:0], idle_word[0]};
                else
                    tx_sr <= {idle_word[0], tx_sr[data_w-1:1]};
            end
            if (rise) begin
                if (msb_first)
                    rx_sr <= {rx_sr[data_w-2:0], miso};   // enters at the bottom
                else
                    rx_sr <= {miso, rx_sr[data_w-1:1]};   // enters at the top
            end
        end
    end

endmodule

// ==== hdl/spi_cmd_queue.sv ====
module spi_cmd_queue (
    input  logic                       sck,
    input  logic                       clr,
    input  logic                       cmd_push,
    input  logic [spi_pkg::data_w-1:0] cmd_data,
    input  logic                       cmd_msb,
    input  logic [spi_pkg::div_w-1:0]  cmd_div,
    output logic                       cmd_full,
    input  logic                       rx_credit,
    spi_xfer_if.issuer                 xfer
);

    import spi_pkg::*;

    // command storage with one array per field
    logic [data_w-1:0]      data_mem [cmd_depth];
    logic                   msb_mem  [cmd_depth];
    logic [div_w-1:0]       div_mem  [cmd_depth];

    logic [cmd_ptr_w-1:0]   wr_ptr;
    logic [cmd_ptr_w-1:0]   rd_ptr;
    logic [cmd_cnt_w-1:0]   count;        // entries held

    logic                   eng_credit;   // single engine credit
    logic [rx_credit_w-1:0] rx_cred;      // free slots in the receive queue

    logic                   push_ok;
    logic                   issue;

    assign cmd_full = (count == cmd_cnt_w'(cmd_depth));
    assign push_ok  = cmd_push && !cmd_full;            // push while full is dropped

    // both credits needed before a command leaves
    assign issue = (count != '0) && eng_credit && (rx_cred != '0);

    //////////////////////////////////////////////////////////////////////
    // storage write and issue payload
    always_ff @(posedge sck) begin
        if (push_ok) begin
            data_mem[wr_ptr] <= cmd_data;
            msb_mem[wr_ptr]  <= cmd_msb;
            div_mem[wr_ptr]  <= cmd_div;
        end
    end

    always_ff @(posedge sck) begin
        if (issue) begin                     // fields line up with start
            xfer.tx_byte   <= data_mem[rd_ptr];
            xfer.msb_first <= msb_mem[rd_ptr];
            xfer.div       <= div_mem[rd_ptr];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers, fill level and credits
    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            eng_credit <= 1'b1;
            rx_cred    <= rx_credit_w'(rx_depth);   // queue starts empty
            xfer.start <= 1'b0;
        end else begin
            xfer.start <= issue;                 // start one cycle after issue
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (issue)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // both or neither
            endcase
            // engine credit comes back with done
            if (issue)
                eng_credit <= 1'b0;
            else if (xfer.done)
                eng_credit <= 1'b1;
            // spent on issue and refunded on each host pop
            case ({rx_credit, issue})
                2'b10:   rx_cred <= rx_cred + 1'b1;
                2'b01:   rx_cred <= rx_cred - 1'b1;
                default: rx_cred <= rx_cred;
            endcase
        end
    end

endmodule

// ==== hdl/spi_xfer_if.sv ====
interface spi_xfer_if;

    import spi_pkg::*;

    // issue fields are valid with start
    logic              start;       // one cycle pulse only while credit is held
    logic [data_w-1:0] tx_byte;     // byte to shift out on mosi
    logic              msb_first;   // bit order of this transfer
    logic [div_w-1:0]  div;         // sclk divider code

    // completion side
    logic              done;        // one cycle pulse that returns engine credit
    logic [data_w-1:0] rx_byte;     // qualified by done

    // command queue end
    modport issuer (
        output start,
        output tx_byte,
        output msb_first,
        output div,
        input  done
    );

    // shift engine end
    modport engine (
        input  start,
        input  tx_byte,
        input  msb_first,
        input  div,
        output done,
        output rx_byte
    );

endinterface

// ==== hdl/spi_pkg.sv ====
package spi_pkg;

    //////////////////////////////////////////////////////////////////////
    // word and divider sizing
    localparam int data_w = 8;                  // bits per spi transfer
    localparam int div_w  = 2;                  // sclk divider code
    localparam int bit_w  = $clog2(data_w);     // engine bit counter

    //////////////////////////////////////////////////////////////////////
    // queues and credits
    localparam int cmd_depth   = 4;
    localparam int cmd_ptr_w   = $clog2(cmd_depth);
    localparam int cmd_cnt_w   = $clog2(cmd_depth + 1);
    localparam int rx_depth    = 4;                      // also the reset credit count
    localparam int rx_ptr_w    = $clog2(rx_depth);
    localparam int rx_credit_w = $clog2(rx_depth + 1);   // holds 0 up to rx_depth

    //////////////////////////////////////////////////////////////////////
    // sclk half period in sck cycles, indexed by divider code
    // code 0 gives sck/4 and code 3 gives sck/32
    localparam int half_w = 5;
    localparam logic [half_w-1:0] half_period [4] = '{5'd2, 5'd4, 5'd8, 5'd16};

    // fill for shifted-out positions and idle mosi level
    localparam logic [data_w-1:0] idle_word = '1;

    // shift engine states
    localparam int st_w = 2;
    localparam logic [st_w-1:0] st_idle   = 2'b00;
    localparam logic [st_w-1:0] st_shift  = 2'b10;
    localparam logic [st_w-1:0] st_finish = 2'b11;

endpackage
